// ==== verilog/matmul_pkg.sv ====
/*
 * Sizes, widths and run step numbers of the 4x4 matrix multiplier
 * Element, address, stride and step types, and the memory row word union
 */
package matmul_pkg;

    ////////////////////
    // Sizes and widths
    ////////////////////
    localparam int mat_size     = 4;
    localparam int elem_width   = 8;
    localparam int addr_width   = 6;
    localparam int ram_depth    = 64;
    localparam int stride_width = 4;
    localparam int step_width   = 5;

    ////////////////////
    // Run step numbers
    ////////////////////
    // Step 0 is idle, operand reads start on step 1
    localparam int step_read_first  = 1;
    localparam int step_write_first = 12;
    localparam int step_done        = 16;

    typedef logic [elem_width-1:0]   elem_t;
    typedef logic [addr_width-1:0]   addr_t;
    typedef logic [stride_width-1:0] stride_t;
    typedef logic [step_width-1:0]   step_t;

    // One memory word, seen flat or as four elements with element 0 in the low byte
    typedef union packed {
        logic [mat_size*elem_width-1:0] bits;
        elem_t [mat_size-1:0]           elem;
    } row_word_u;

endpackage

// ==== verilog/dual_port_ram.sv ====
/*
 * Two-port matrix memory with per-element write enables
 */
module dual_port_ram (
    input  logic                           clk,
    input  matmul_pkg::addr_t              addr0,
    input  matmul_pkg::row_word_u          wdata0,
    input  logic [matmul_pkg::mat_size-1:0] we0,
    output matmul_pkg::row_word_u          rdata0,
    input  matmul_pkg::addr_t              addr1,
    input  matmul_pkg::row_word_u          wdata1,
    input  logic [matmul_pkg::mat_size-1:0] we1,
    output matmul_pkg::row_word_u          rdata1
);
    import matmul_pkg::*;

    row_word_u mem [ram_depth];

    // Both ports share one process, so port 1 wins when both write the same element
    always_ff @(posedge clk) begin
        for (int e = 0; e < mat_size; e++) begin
            if (we0[e])
                mem[addr0].elem[e] <= wdata0.elem[e];
            if (we1[e])
                mem[addr1].elem[e] <= wdata1.elem[e];
        end
        // Read data shows up one cycle after the address
        rdata0 <= mem[addr0];
        rdata1 <= mem[addr1];
    end

endmodule

// ==== verilog/matmul_config_regs.sv ====
/*
 * Run configuration registers for base addresses and strides
 */
module matmul_config_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                run_begin,
    input  matmul_pkg::addr_t   addr_a,
    input  matmul_pkg::addr_t   addr_b,
    input  matmul_pkg::addr_t   addr_c,
    input  matmul_pkg::stride_t stride_a,
    input  matmul_pkg::stride_t stride_b,
    input  matmul_pkg::stride_t stride_c,
    output matmul_pkg::addr_t   base_a,
    output matmul_pkg::addr_t   base_b,
    output matmul_pkg::addr_t   base_c,
    output matmul_pkg::stride_t step_a,
    output matmul_pkg::stride_t step_b,
    output matmul_pkg::stride_t step_c
);

    // The inputs are sampled only on the accepting edge and held for the whole run
    always_ff @(posedge clk) begin
        if (reset) begin
            base_a <= '0;
            base_b <= '0;
            base_c <= '0;
            step_a <= '0;
            step_b <= '0;
            step_c <= '0;
        end else if (run_begin) begin
            base_a <= addr_a;
            base_b <= addr_b;
            base_c <= addr_c;
            step_a <= stride_a;
            step_b <= stride_b;
            step_c <= stride_c;
        end
    end

endmodule

// ==== verilog/run_sequencer.sv ====
/*
 * Run control with the step counter and the done pulse
 */
module run_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output logic              run_begin,
    output matmul_pkg::step_t step,
    output logic              done
);
    import matmul_pkg::*;

    logic busy;

    // Step zero is the idle state, any other step means a run is in flight
    assign busy = (step != '0);

    // A start while busy is dropped
    assign run_begin = start && !busy;

    assign done = (step == step_t'(step_done));

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= '0;
        end else if (run_begin) begin
            step <= step_t'(step_read_first);
        end else if (done) begin
            step <= '0;
        end else if (busy) begin
            step <= step + step_t'(1);
        end
    end

endmodule

// ==== verilog/operand_feeder.sv ====
/*
 * Operand read address generation and the triangular skew into the mesh
 */
module operand_feeder (
    input  logic                  clk,
    input  logic                  reset,
    input  matmul_pkg::step_t     step,
    input  matmul_pkg::addr_t     base_a,
    input  matmul_pkg::addr_t     base_b,
    input  matmul_pkg::stride_t   step_a,
    input  matmul_pkg::stride_t   step_b,
    output matmul_pkg::addr_t     a_addr,
    output matmul_pkg::addr_t     b_addr,
    input  matmul_pkg::row_word_u a_rdata,
    input  matmul_pkg::row_word_u b_rdata,
    output matmul_pkg::row_word_u a_feed,
    output matmul_pkg::row_word_u b_feed
);
    import matmul_pkg::*;

    step_t rd_offset;
    addr_t rd_k;
    logic  rd_step;
    logic  rd_valid;
    elem_t a_lane [mat_size];
    elem_t b_lane [mat_size];

    // Operand index k counts from the first read step
    assign rd_offset = step - step_t'(step_read_first);
    assign rd_k      = addr_t'(rd_offset);
    assign rd_step   = (step >= step_t'(step_read_first)) &&
                       (step < step_t'(step_read_first + mat_size));

    assign a_addr = base_a + rd_k * addr_t'(step_a);
    assign b_addr = base_b + rd_k * addr_t'(step_b);

    // Marks the cycles in which the memory returns a requested word
    always_ff @(posedge clk) begin
        if (reset)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_step;
    end

    ////////////////////
    // Skew registers
    ////////////////////
    // Lane i of both operands gets i register stages, lane 0 goes straight in
    for (genvar i = 0; i < mat_size; i++) begin : g_lane
        elem_t a_in;
        elem_t b_in;

        assign a_in = rd_valid ? a_rdata.elem[i] : '0;
        assign b_in = rd_valid ? b_rdata.elem[i] : '0;

        if (i == 0) begin : g_direct
            assign a_lane[i] = a_in;
            assign b_lane[i] = b_in;
        end else begin : g_skew
            elem_t a_pipe [i];
            elem_t b_pipe [i];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int d = 0; d < i; d++) begin
                        a_pipe[d] <= '0;
                        b_pipe[d] <= '0;
                    end
                end else begin
                    a_pipe[0] <= a_in;
                    b_pipe[0] <= b_in;
                    for (int d = 1; d < i; d++) begin
                        a_pipe[d] <= a_pipe[d-1];
                        b_pipe[d] <= b_pipe[d-1];
                    end
                end
            end

            assign a_lane[i] = a_pipe[i-1];
            assign b_lane[i] = b_pipe[i-1];
        end
    end

    always_comb begin
        for (int i = 0; i < mat_size; i++) begin
            a_feed.elem[i] = a_lane[i];
            b_feed.elem[i] = b_lane[i];
        end
    end

endmodule

// ==== verilog/processing_element.sv ====
/*
 * Mesh cell with an 8-bit wraparound multiply-accumulate
 */
module processing_element (
    input  logic              clk,
    input  logic              reset,
    input  logic              clear,
    input  matmul_pkg::elem_t in_a,
    input  matmul_pkg::elem_t in_b,
    output matmul_pkg::elem_t out_a,
    output matmul_pkg::elem_t out_b,
    output matmul_pkg::elem_t acc
);
    import matmul_pkg::*;

    elem_t product;

    assign product = in_a * in_b;

    // Only the low byte of each product is kept, so the sum wraps modulo 256
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            acc <= '0;
        end else begin
            acc <= acc + product;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_a <= '0;
            out_b <= '0;
        end else begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

endmodule

// ==== verilog/systolic_array.sv ====
/*
 * 4x4 mesh of processing elements and packing of the accumulator rows
 */
module systolic_array (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  matmul_pkg::row_word_u a_feed,
    input  matmul_pkg::row_word_u b_feed,
    output matmul_pkg::row_word_u c_rows [matmul_pkg::mat_size]
);
    import matmul_pkg::*;

    // A moves right along a row, B moves down a column
    elem_t a_link [mat_size][mat_size+1];
    elem_t b_link [mat_size+1][mat_size];
    elem_t acc    [mat_size][mat_size];

    for (genvar i = 0; i < mat_size; i++) begin : g_row
        assign a_link[i][0] = a_feed.elem[i];
        assign b_link[0][i] = b_feed.elem[i];

        for (genvar j = 0; j < mat_size; j++) begin : g_col
            processing_element u_pe (
                .clk   (clk),
                .reset (reset),
                .clear (clear),
                .in_a  (a_link[i][j]),
                .in_b  (b_link[i][j]),
                .out_a (a_link[i][j+1]),
                .out_b (b_link[i+1][j]),
                .acc   (acc[i][j])
            );
        end
    end

    always_comb begin
        for (int i = 0; i < mat_size; i++) begin
            for (int j = 0; j < mat_size; j++)
                c_rows[i].elem[j] = acc[i][j];
        end
    end

endmodule

// ==== verilog/result_writer.sv ====
/*
 * Write-back of the four result rows into memory C
 */
module result_writer (
    input  logic                            clk,
    input  logic                            reset,
    input  matmul_pkg::step_t               step,
    input  matmul_pkg::addr_t               base_c,
    input  matmul_pkg::stride_t             step_c,
    input  matmul_pkg::row_word_u           c_rows [matmul_pkg::mat_size],
    output matmul_pkg::addr_t               c_addr,
    output matmul_pkg::row_word_u           c_wdata,
    output logic [matmul_pkg::mat_size-1:0] c_we
);
    import matmul_pkg::*;

    step_t                       row_offset;
    logic [$clog2(mat_size)-1:0] row_next;
    logic [$clog2(mat_size)-1:0] row_sel;
    logic                        wr_next;

    // Strobes are set up one step early so the writes land on steps 12 to 15
    assign row_offset = step - step_t'(step_write_first - 1);
    assign row_next   = row_offset[$clog2(mat_size)-1:0];
    assign wr_next    = (step >= step_t'(step_write_first - 1)) &&
                        (step < step_t'(step_write_first - 1 + mat_size));

    always_ff @(posedge clk) begin
        if (reset) begin
            c_we    <= '0;
            row_sel <= '0;
            c_addr  <= '0;
        end else begin
            c_we <= wr_next ? '1 : '0;
            if (wr_next) begin
                row_sel <= row_next;
                c_addr  <= base_c + addr_t'(row_next) * addr_t'(step_c);
            end
        end
    end

    // Accumulators are final after step 11 and hold while zeros flow in
    assign c_wdata = c_rows[row_sel];

endmodule

// ==== verilog/matmul_top.sv ====
/*
 * Matrix multiplier top level with memories A, B and C,
 * the run configuration, the sequencer and the systolic datapath
 */
module matmul_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  matmul_pkg::addr_t               addr_a,
    input  matmul_pkg::addr_t               addr_b,
    input  matmul_pkg::addr_t               addr_c,
    input  matmul_pkg::stride_t             stride_a,
    input  matmul_pkg::stride_t             stride_b,
    input  matmul_pkg::stride_t             stride_c,
    input  matmul_pkg::addr_t               ext_addr_a,
    input  matmul_pkg::addr_t               ext_addr_b,
    input  matmul_pkg::addr_t               ext_addr_c,
    input  matmul_pkg::row_word_u           ext_wdata_a,
    input  matmul_pkg::row_word_u           ext_wdata_b,
    input  matmul_pkg::row_word_u           ext_wdata_c,
    input  logic [matmul_pkg::mat_size-1:0] ext_we_a,
    input  logic [matmul_pkg::mat_size-1:0] ext_we_b,
    input  logic [matmul_pkg::mat_size-1:0] ext_we_c,
    output matmul_pkg::row_word_u           ext_rdata_c,
    output logic                            done
);
    import matmul_pkg::*;

    logic                run_begin;
    step_t               step;
    addr_t               base_a;
    addr_t               base_b;
    addr_t               base_c;
    stride_t             step_a;
    stride_t             step_b;
    stride_t             step_c;
    addr_t               a_addr;
    addr_t               b_addr;
    addr_t               c_addr;
    row_word_u           a_rdata;
    row_word_u           b_rdata;
    row_word_u           a_feed;
    row_word_u           b_feed;
    row_word_u           c_rows [mat_size];
    row_word_u           c_wdata;
    logic [mat_size-1:0] c_we;

    ////////////////////
    // Matrix memories
    ////////////////////
    // Port 0 belongs to the datapath, port 1 to the outside world
    dual_port_ram u_ram_a (
        .clk    (clk),
        .addr0  (a_addr),     .wdata0 ('0),          .we0 ('0),       .rdata0 (a_rdata),
        .addr1  (ext_addr_a), .wdata1 (ext_wdata_a), .we1 (ext_we_a), .rdata1 ()
    );

    dual_port_ram u_ram_b (
        .clk    (clk),
        .addr0  (b_addr),     .wdata0 ('0),          .we0 ('0),       .rdata0 (b_rdata),
        .addr1  (ext_addr_b), .wdata1 (ext_wdata_b), .we1 (ext_we_b), .rdata1 ()
    );

    dual_port_ram u_ram_c (
        .clk    (clk),
        .addr0  (c_addr),     .wdata0 (c_wdata),     .we0 (c_we),     .rdata0 (),
        .addr1  (ext_addr_c), .wdata1 (ext_wdata_c), .we1 (ext_we_c), .rdata1 (ext_rdata_c)
    );

    ////////////////////
    // Control
    ////////////////////
    run_sequencer u_run_sequencer (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .run_begin (run_begin),
        .step      (step),
        .done      (done)
    );

    matmul_config_regs u_config_regs (
        .clk       (clk),
        .reset     (reset),
        .run_begin (run_begin),
        .addr_a    (addr_a),   .addr_b   (addr_b),   .addr_c   (addr_c),
        .stride_a  (stride_a), .stride_b (stride_b), .stride_c (stride_c),
        .base_a    (base_a),   .base_b   (base_b),   .base_c   (base_c),
        .step_a    (step_a),   .step_b   (step_b),   .step_c   (step_c)
    );

    ////////////////////
    // Datapath
    ////////////////////
    operand_feeder u_operand_feeder (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .base_a  (base_a),  .base_b  (base_b),
        .step_a  (step_a),  .step_b  (step_b),
        .a_addr  (a_addr),  .b_addr  (b_addr),
        .a_rdata (a_rdata), .b_rdata (b_rdata),
        .a_feed  (a_feed),  .b_feed  (b_feed)
    );

    // The accumulators clear on the same edge that accepts the run
    systolic_array u_systolic_array (
        .clk    (clk),
        .reset  (reset),
        .clear  (run_begin),
        .a_feed (a_feed),
        .b_feed (b_feed),
        .c_rows (c_rows)
    );

    result_writer u_result_writer (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .base_c  (base_c),
        .step_c  (step_c),
        .c_rows  (c_rows),
        .c_addr  (c_addr),
        .c_wdata (c_wdata),
        .c_we    (c_we)
    );

endmodule

// ==== verif/clock_gen.sv ====
/*
 * Free-running testbench clock
 */
module clock_gen #(
    parameter int period = 40
) (
    output logic clk
);

    initial clk = 1'b0;

    // Half a period low, half a period high
    always #(period / 2) clk = ~clk;

endmodule

// ==== verif/matmul_assertions.sv ====
/*
 * Concurrent assertions on the done pulse and the memory C write strobes
 */
module matmul_assertions (
    input logic                            clk,
    input logic                            reset,
    input logic                            done,
    input matmul_pkg::step_t               step,
    input logic [matmul_pkg::mat_size-1:0] c_we
);
    import matmul_pkg::*;

    // A run ends with a single-cycle done pulse
    done_single_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done was high on two consecutive cycles");

    done_low_after_reset: assert property (@(posedge clk) reset |=> !done)
        else $error("done was high in the cycle after reset");

    // Memory C is only written by a run in flight
    no_write_when_idle: assert property (
        @(posedge clk) disable iff (reset) (step == '0) |-> (c_we == '0)
    ) else $error("memory C write strobe active while idle");

endmodule

bind matmul_top matmul_assertions u_matmul_assertions (
    .clk   (clk),
    .reset (reset),
    .done  (done),
    .step  (step),
    .c_we  (c_we)
);

// ==== verif/matmul_tb.sv ====
/*
 * Table-driven testbench for the systolic matrix multiplier
 * with a modulo-256 reference model and typed compare tasks
 */
module matmul_tb;
    import matmul_pkg::*;

    localparam int drive_delay  = 5;
    localparam int reset_cycles = 5;
    localparam int done_timeout = 40;
    localparam int done_latency = 16;
    localparam int num_cases    = 7;

    localparam logic [1:0] kind_identity = 2'd0;
    localparam logic [1:0] kind_zeros    = 2'd1;
    localparam logic [1:0] kind_all_ones = 2'd2;
    localparam logic [1:0] kind_random   = 2'd3;

    typedef struct packed {
        addr_t      a;
        addr_t      b;
        addr_t      c;
        stride_t    sa;
        stride_t    sb;
        stride_t    sc;
        logic [1:0] kind;
        logic       busy_start;
    } case_t;

    logic                clk;
    logic                reset;
    logic                start;
    addr_t               addr_a;
    addr_t               addr_b;
    addr_t               addr_c;
    stride_t             stride_a;
    stride_t             stride_b;
    stride_t             stride_c;
    addr_t               ext_addr_a;
    addr_t               ext_addr_b;
    addr_t               ext_addr_c;
    row_word_u           ext_wdata_a;
    row_word_u           ext_wdata_b;
    row_word_u           ext_wdata_c;
    logic [mat_size-1:0] ext_we_a;
    logic [mat_size-1:0] ext_we_b;
    logic [mat_size-1:0] ext_we_c;
    row_word_u           ext_rdata_c;
    logic                done;

    case_t  cases [num_cases];
    int     a_mat [mat_size][mat_size];
    int     b_mat [mat_size][mat_size];
    integer seed;

    clock_gen #(.period(40)) u_clock_gen (.clk(clk));

    matmul_top u_matmul_top (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .addr_a      (addr_a),      .addr_b      (addr_b),      .addr_c      (addr_c),
        .stride_a    (stride_a),    .stride_b    (stride_b),    .stride_c    (stride_c),
        .ext_addr_a  (ext_addr_a),  .ext_addr_b  (ext_addr_b),  .ext_addr_c  (ext_addr_c),
        .ext_wdata_a (ext_wdata_a), .ext_wdata_b (ext_wdata_b), .ext_wdata_c (ext_wdata_c),
        .ext_we_a    (ext_we_a),    .ext_we_b    (ext_we_b),    .ext_we_c    (ext_we_c),
        .ext_rdata_c (ext_rdata_c),
        .done        (done)
    );

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_row(input string name, input row_word_u expected, input row_word_u actual);
        if (actual !== expected) begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected.bits,
                     actual.bits);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Inputs change a little after the rising edge, outputs are read there too
    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic fill_table();
        cases[0] = '{6'd0,  6'd0,  6'd0,  4'd1,  4'd1, 4'd1, kind_identity, 1'b0};
        cases[1] = '{6'd3,  6'd10, 6'd20, 4'd1,  4'd2, 4'd5, kind_random,   1'b0};
        cases[2] = '{6'd8,  6'd40, 6'd2,  4'd2,  4'd3, 4'd4, kind_all_ones, 1'b0};
        // Same locations as the previous entry, so leftover sums would show
        cases[3] = '{6'd8,  6'd40, 6'd2,  4'd2,  4'd3, 4'd4, kind_zeros,    1'b0};
        cases[4] = '{6'd16, 6'd5,  6'd44, 4'd5,  4'd1, 4'd3, kind_random,   1'b1};
        cases[5] = '{6'd1,  6'd1,  6'd60, 4'd4,  4'd4, 4'd1, kind_random,   1'b0};
        cases[6] = '{6'd0,  6'd2,  6'd7,  4'd15, 4'd7, 4'd9, kind_identity, 1'b1};
    endtask

    task automatic fill_matrices(input logic [1:0] kind);
        for (int i = 0; i < mat_size; i++) begin
            for (int j = 0; j < mat_size; j++) begin
                case (kind)
                    kind_identity: a_mat[i][j] = (i == j) ? 1 : 0;
                    kind_zeros:    a_mat[i][j] = 0;
                    kind_all_ones: a_mat[i][j] = 255;
                    default:       a_mat[i][j] = $random(seed) & 255;
                endcase
                case (kind)
                    kind_zeros:    b_mat[i][j] = 0;
                    kind_all_ones: b_mat[i][j] = 255;
                    default:       b_mat[i][j] = $random(seed) & 255;
                endcase
            end
        end
    endtask

    // A goes in column by column, B row by row, and C is filled with a marker
    task automatic load_operands(input case_t tc);
        for (int k = 0; k < mat_size; k++) begin
            ext_addr_a = addr_t'(int'(tc.a) + k * int'(tc.sa));
            ext_addr_b = addr_t'(int'(tc.b) + k * int'(tc.sb));
            ext_addr_c = addr_t'(int'(tc.c) + k * int'(tc.sc));
            for (int e = 0; e < mat_size; e++) begin
                ext_wdata_a.elem[e] = elem_t'(a_mat[e][k]);
                ext_wdata_b.elem[e] = elem_t'(b_mat[k][e]);
            end
            ext_wdata_c.bits = 32'h5a5a_5a5a ^ k;
            ext_we_a = '1;
            ext_we_b = '1;
            ext_we_c = '1;
            next_cycle();
        end
        ext_we_a = '0;
        ext_we_b = '0;
        ext_we_c = '0;
    endtask

    task automatic run_until_done(input case_t tc);
        int cycles;

        addr_a   = tc.a;
        addr_b   = tc.b;
        addr_c   = tc.c;
        stride_a = tc.sa;
        stride_b = tc.sb;
        stride_c = tc.sc;
        start    = 1'b1;
        next_cycle();
        cycles = 1;
        start  = tc.busy_start;
        // The run uses the copy taken at the accepting edge, so these values must not matter
        addr_a   = ~tc.a;
        addr_b   = ~tc.b;
        addr_c   = ~tc.c;
        stride_a = ~tc.sa;
        stride_b = ~tc.sb;
        stride_c = ~tc.sc;
        while (done !== 1'b1) begin
            if (cycles >= done_timeout) begin
                $display("Timeout: done never arrived within %0d cycles", done_timeout);
                $display("Verification failed");
                $fatal(1, "no done pulse");
            end
            next_cycle();
            cycles++;
            // Start stays high for a while and comes back once mid-run
            if (tc.busy_start)
                start = (cycles < 4) || (cycles == 8);
        end
        start = 1'b0;
        check_count("done latency", done_latency, cycles);
        // A second pulse here would mean a repeated start was taken
        for (int n = 0; n < 20; n++) begin
            next_cycle();
            check_bit("done", 1'b0, done);
        end
    endtask

    function automatic row_word_u expected_row(input int i);
        row_word_u row;
        int        sum;

        for (int j = 0; j < mat_size; j++) begin
            sum = 0;
            for (int k = 0; k < mat_size; k++)
                sum += a_mat[i][k] * b_mat[k][j];
            row.elem[j] = elem_t'(sum % 256);
        end
        return row;
    endfunction

    task automatic read_results(input case_t tc);
        for (int i = 0; i < mat_size; i++) begin
            ext_addr_c = addr_t'(int'(tc.c) + i * int'(tc.sc));
            next_cycle();
            check_row($sformatf("ext_rdata_c row %0d", i), expected_row(i), ext_rdata_c);
        end
    endtask

    initial begin
        seed        = 99864;
        reset       = 1'b1;
        start       = 1'b0;
        addr_a      = '0;
        addr_b      = '0;
        addr_c      = '0;
        stride_a    = '0;
        stride_b    = '0;
        stride_c    = '0;
        ext_addr_a  = '0;
        ext_addr_b  = '0;
        ext_addr_c  = '0;
        ext_wdata_a = '0;
        ext_wdata_b = '0;
        ext_wdata_c = '0;
        ext_we_a    = '0;
        ext_we_b    = '0;
        ext_we_c    = '0;
        fill_table();

        repeat (reset_cycles) next_cycle();
        reset = 1'b0;

        // Quiet period with no start
        for (int n = 0; n < 20; n++) begin
            next_cycle();
            check_bit("done", 1'b0, done);
        end

        for (int t = 0; t < num_cases; t++) begin
            fill_matrices(cases[t].kind);
            load_operands(cases[t]);
            run_until_done(cases[t]);
            read_results(cases[t]);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== files.f ====
verilog/matmul_pkg.sv
verilog/dual_port_ram.sv
verilog/matmul_config_regs.sv
verilog/run_sequencer.sv
verilog/operand_feeder.sv
verilog/processing_element.sv
verilog/systolic_array.sv
verilog/result_writer.sv
verilog/matmul_top.sv
verif/clock_gen.sv
verif/matmul_assertions.sv
verif/matmul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the matrix multiplier testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module matmul_tb \
    -f files.f -o matmul_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/matmul_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
